// File: src/qsnd_pkg.sv
/* shared types and constants for the sound board glue logic
   all timing constants count cen8 ticks of the 48 MHz clock */
`default_nettype none

package qsnd_pkg;

    typedef logic [15:0]        snd_addr_t;   // sound CPU address
    typedef logic [7:0]         byte_t;
    typedef logic [18:0]        rom_addr_t;   // program ROM, 512 kB
    typedef logic [22:0]        qrom_addr_t;  // sample ROM, up to 8 MB
    typedef logic [12:0]        ram_addr_t;   // 8 kB work RAM
    typedef logic signed [15:0] sample_t;

    // sound CPU bus, strobes active low
    typedef struct packed {
        snd_addr_t addr;
        byte_t     dout;
        logic      mreq_n;
        logic      rd_n;
        logic      wr_n;
        logic      m1_n;
        logic      iorq_n;
    } snd_bus_t;

    // main CPU side of the shared bus
    typedef struct packed {
        logic [23:1] addr;    // word address
        byte_t       dout;
        logic        ldsw_n;  // low byte write
        logic        buse_n;  // bus request
    } main_bus_t;

    // DSP outputs seen by the glue logic
    typedef struct packed {
        logic [15:0] pbus_out;
        logic        pods_n;
        logic        pids_n;
        logic        iack;
        logic        sadd;
        logic        psel;
        logic [15:0] ser_out;
        logic [15:0] ab;
        logic        cen_cko;
    } dsp_pio_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } audio_t;

    localparam rom_addr_t   BANK_BASE  = 19'h0_8000;
    localparam int          IRQ_PERIOD = 32000;          // cen8 ticks
    localparam int          IRQ_CW     = $clog2(IRQ_PERIOD);
    localparam logic [3:0]  WAIT_ADDR  = 4'h4;           // address nibble

endpackage

`default_nettype wire

// File: src/qsnd_bus_lock.sv
/* main CPU takes the sound bus two cen8 ticks after the sound CPU acknowledges;
   releasing buse_n hands the bus back on the next clock */
`timescale 1ns/1ps
`default_nettype none

module qsnd_bus_lock (
    input  wire  clk48,
    input  wire  rst,
    input  wire  cen8,
    input  wire  buse_n,
    input  wire  busak_n,
    output logic busrq_n,
    output logic main_busak_n
);

    logic [1:0] lock_sr;  // request and acknowledge, delayed

    // the request goes straight to the sound CPU
    assign busrq_n      = buse_n;
    assign main_busak_n = lock_sr[1];

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            lock_sr <= 2'b11;
        end else begin
            if (buse_n) begin
                lock_sr <= 2'b11;  // released, drop at once
            end else if (cen8) begin
                lock_sr <= {lock_sr[0], busrq_n | busak_n};
            end
        end
    end

endmodule

`default_nettype wire

// File: src/qsnd_irq_timer.sv
/* periodic sound CPU interrupt, cleared by the interrupt acknowledge cycle */
`timescale 1ns/1ps
`default_nettype none

module qsnd_irq_timer (
    input  wire  clk48,
    input  wire  rst,
    input  wire  cen8,
    input  wire  m1_n,
    input  wire  iorq_n,
    output logic int_n
);

    import qsnd_pkg::*;

    logic [IRQ_CW-1:0] cnt;
    logic              wrap;

    assign wrap = cnt == IRQ_CW'(IRQ_PERIOD - 1);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= wrap ? '0 : cnt + 1'b1;
            if (!m1_n && !iorq_n) begin
                int_n <= 1'b1;  // ack wins over a new wrap
            end else if (wrap) begin
                int_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/qsnd_mem_decode.sv
/* sound memory map decode; while the main CPU owns the bus its memory request
   is always active and ldsw_n is the write strobe */
`timescale 1ns/1ps
`default_nettype none

module qsnd_mem_decode (
    input  wire                      clk48,
    input  wire                      rst,
    input  wire                      cen8,
    input  wire qsnd_pkg::snd_bus_t  snd,
    input  wire qsnd_pkg::main_bus_t main,
    input  wire                      main_busak_n,
    input  wire qsnd_pkg::byte_t     rom_data,
    input  wire                      rom_ok,
    input  wire qsnd_pkg::byte_t     ram_q,
    input  wire                      dsp_irq,
    input  wire                      dsp_iack,
    output qsnd_pkg::rom_addr_t      rom_addr,
    output logic                     rom_cs,
    output qsnd_pkg::ram_addr_t      ram_addr,
    output qsnd_pkg::byte_t          ram_wdata,
    output logic                     ram_we,
    output logic                     qsnd_wr,
    output logic [1:0]               qsnd_reg,
    output qsnd_pkg::byte_t          bus_wdata,
    output logic                     dsp_rst,
    output logic                     cpu_cen,
    output qsnd_pkg::byte_t          cpu_din
);

    import qsnd_pkg::*;

    snd_addr_t  bus_addr;
    logic       bus_mreq_n;
    logic       bus_wr_n;
    logic       bus_rd_n;
    logic       in_d_page;
    logic       wr_sel;
    logic       wr_sel_q;
    logic       ram_cs;
    logic       bank_cs;
    logic       stat_cs;
    logic [3:0] bank;
    byte_t      status;
    logic       fetch_hi;
    logic       wait_done;

    // bus owner mux
    assign bus_addr   = main_busak_n ? snd.addr   : main.addr[16:1];
    assign bus_mreq_n = main_busak_n ? snd.mreq_n : 1'b0;
    assign bus_wr_n   = main_busak_n ? snd.wr_n   : main.ldsw_n;
    assign bus_rd_n   = main_busak_n ? snd.rd_n   : ~main.ldsw_n;
    assign bus_wdata  = main_busak_n ? snd.dout   : main.dout;

    assign in_d_page = bus_addr[15:12] == 4'hd;
    assign wr_sel    = !bus_mreq_n && !bus_wr_n && in_d_page && bus_addr[2:0] <= 3'd2;

    assign ram_addr  = bus_addr[12:0];  // C000 and F000 land in different halves
    assign ram_wdata = bus_wdata;
    assign ram_we    = ram_cs && !bus_wr_n;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            rom_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            bank_cs  <= 1'b0;
            stat_cs  <= 1'b0;
            qsnd_wr  <= 1'b0;
            qsnd_reg <= 2'd0;
            wr_sel_q <= 1'b0;
            rom_addr <= '0;
        end else begin
            rom_cs  <= !bus_mreq_n && (!bus_addr[15] || bus_addr[15:14] == 2'b10);
            ram_cs  <= !bus_mreq_n && (bus_addr[15:12] == 4'hc || bus_addr[15:12] == 4'hf);
            bank_cs <= !bus_mreq_n && !bus_wr_n && in_d_page && bus_addr[2:0] == 3'd3;
            stat_cs <= !bus_mreq_n && !bus_rd_n && in_d_page && bus_addr[2:0] == 3'd7;
            // one strobe per write, or per register change
            wr_sel_q <= wr_sel;
            qsnd_wr  <= wr_sel && (!wr_sel_q || qsnd_reg != bus_addr[1:0]);
            if (wr_sel) begin
                qsnd_reg <= bus_addr[1:0];
            end
            if (!bus_mreq_n) begin
                rom_addr <= bus_addr[15] ? ({1'b0, bank, bus_addr[13:0]} + BANK_BASE)
                                         : {4'd0, bus_addr[14:0]};
            end
        end
    end

    // bank and DSP reset register at D003
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            bank    <= 4'd0;
            dsp_rst <= 1'b1;
        end else if (bank_cs) begin
            bank    <= bus_wdata[3:0];
            dsp_rst <= ~bus_wdata[7];
        end
    end

    assign status = {~(dsp_irq | dsp_iack), 3'b111, bank};

    always_comb begin
        if (rom_cs) begin
            cpu_din = rom_ok ? rom_data : 8'hff;
        end else if (ram_cs) begin
            cpu_din = ram_q;
        end else if (stat_cs) begin
            cpu_din = status;
        end else begin
            cpu_din = 8'hff;
        end
    end

    // extra wait on opcode fetches from the upper ROM
    assign fetch_hi = !snd.m1_n && snd.iorq_n && snd.addr[15:12] >= WAIT_ADDR;
    assign cpu_cen  = cen8 && !(fetch_hi && !wait_done);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            wait_done <= 1'b0;
        end else if (snd.m1_n) begin
            wait_done <= 1'b0;
        end else if (cen8 && fetch_hi) begin
            wait_done <= 1'b1;  // this tick was the dropped one
        end
    end

endmodule

`default_nettype wire

// File: src/qsnd_work_ram.sv
/* 8 kB work RAM, read data registered, contents undefined after power up */
`timescale 1ns/1ps
`default_nettype none

module qsnd_work_ram (
    input  wire                      clk48,
    input  wire qsnd_pkg::ram_addr_t addr,
    input  wire qsnd_pkg::byte_t     wdata,
    input  wire                      we,
    output qsnd_pkg::byte_t          q
);

    import qsnd_pkg::*;

    byte_t mem [0:(1 << $bits(ram_addr_t)) - 1];

    always_ff @(posedge clk48) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr];  // old data on a write cycle
    end

endmodule

`default_nettype wire

// File: src/qsnd_dsp_port.sv
/* DSP parallel port, sample ROM address latch and audio capture
   DSP strobes are taken as synchronous to clk48 */
`timescale 1ns/1ps
`default_nettype none

module qsnd_dsp_port (
    input  wire                     clk48,
    input  wire                     rst,
    input  wire                     qsnd_wr,
    input  wire [1:0]               qsnd_reg,
    input  wire qsnd_pkg::byte_t    wdata,
    input  wire qsnd_pkg::dsp_pio_t dsp,
    output logic                    dsp_irq,
    output logic [15:0]             pbus_in,
    output qsnd_pkg::qrom_addr_t    qsnd_addr,
    output qsnd_pkg::audio_t        audio,
    output logic                    sample
);

    import qsnd_pkg::*;

    logic [23:0] cpu2dsp;  // address byte on top, data word below
    logic [1:0]  datasel;
    logic        last_pids_n;
    logic        last_pods_n;
    logic        last_sadd;
    logic        last_psel;
    logic        pids_rise;
    logic        pods_rise;
    logic        sadd_fall;
    logic        psel_rise;
    sample_t     reg_left;
    sample_t     reg_right;

    assign pids_rise = dsp.pids_n && !last_pids_n;
    assign pods_rise = dsp.pods_n && !last_pods_n;
    assign sadd_fall = !dsp.sadd && last_sadd;
    assign psel_rise = dsp.psel && !last_psel;

    // command latch
    always_ff @(posedge clk48) begin
        if (qsnd_wr) begin
            case (qsnd_reg)
                2'd0:    cpu2dsp[15:8]  <= wdata;  // data MSB
                2'd1:    cpu2dsp[7:0]   <= wdata;  // data LSB
                default: cpu2dsp[23:16] <= wdata;  // address
            endcase
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            dsp_irq     <= 1'b0;
            datasel     <= 2'b00;
            last_pids_n <= 1'b1;
            last_pods_n <= 1'b1;
            last_sadd   <= 1'b0;
            last_psel   <= 1'b0;
        end else begin
            last_pids_n <= dsp.pids_n;
            last_pods_n <= dsp.pods_n;
            last_sadd   <= dsp.sadd;
            last_psel   <= dsp.psel;
            if (qsnd_wr && qsnd_reg == 2'd2) begin
                dsp_irq <= 1'b1;
                datasel <= 2'b11;
            end else if (pids_rise) begin
                dsp_irq <= 1'b0;  // DSP has read the address
                datasel <= datasel >> 1;
            end
        end
    end

    assign pbus_in = datasel[1] ? {8'd0, cpu2dsp[23:16]} : cpu2dsp[15:0];

    // serial words taken in parallel
    always_ff @(posedge clk48) begin
        if (sadd_fall) begin
            if (dsp.psel) begin
                reg_right <= dsp.ser_out;
            end else begin
                reg_left <= dsp.ser_out;
            end
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            qsnd_addr <= '0;
            audio     <= '0;
            sample    <= 1'b0;
        end else begin
            sample <= psel_rise;
            if (psel_rise) begin
                audio.left  <= reg_left;
                audio.right <= reg_right;
            end
            if (pods_rise) begin
                qsnd_addr[15:0] <= dsp.pbus_out;
            end
            if (dsp.ab[15] && dsp.cen_cko) begin
                qsnd_addr[22:16] <= dsp.ab[6:0];  // upper bits on external access
            end
        end
    end

endmodule

`default_nettype wire

// File: src/qsnd_sound_top.sv
/* sound board glue top; sound CPU and DSP are outside, all logic on clk48 with cen8
   main_busak_n stays high while a ROM read waits for rom_ok */
`timescale 1ns/1ps
`default_nettype none

module qsnd_sound_top (
    input  wire                      clk48,
    input  wire                      rst,
    input  wire                      cen8,
    input  wire qsnd_pkg::snd_bus_t  snd,
    input  wire                      busak_n,
    input  wire qsnd_pkg::main_bus_t main,
    input  wire qsnd_pkg::byte_t     rom_data,
    input  wire                      rom_ok,
    input  wire qsnd_pkg::byte_t     qsnd_data,
    input  wire qsnd_pkg::dsp_pio_t  dsp,
    output qsnd_pkg::byte_t          main_din,
    output logic                     main_busak_n,
    output logic                     busrq_n,
    output logic                     int_n,
    output logic                     cpu_cen,
    output qsnd_pkg::byte_t          cpu_din,
    output qsnd_pkg::rom_addr_t      rom_addr,
    output logic                     rom_cs,
    output qsnd_pkg::qrom_addr_t     qsnd_addr,
    output logic                     qsnd_cs,
    output logic                     dsp_rst,
    output logic                     dsp_irq,
    output logic [15:0]              pbus_in,
    output logic [15:0]              rb_din,
    output qsnd_pkg::sample_t        left,
    output qsnd_pkg::sample_t        right,
    output logic                     sample
);

    import qsnd_pkg::*;

    logic       lock_busak_n;  // before ROM back-pressure
    ram_addr_t  ram_addr;
    byte_t      ram_wdata;
    byte_t      ram_q;
    byte_t      bus_wdata;
    logic       ram_we;
    logic       qsnd_wr;
    logic [1:0] qsnd_reg;
    audio_t     audio;

    assign main_busak_n = lock_busak_n | (rom_cs & ~rom_ok);
    assign rb_din       = {qsnd_data, 8'h00};  // sample ROM on the upper byte
    assign qsnd_cs      = 1'b1;
    assign left         = audio.left;
    assign right        = audio.right;

    always_ff @(posedge clk48) begin
        main_din <= cpu_din;
    end

    qsnd_bus_lock u_bus_lock (
        .clk48        (clk48),
        .rst          (rst),
        .cen8         (cen8),
        .buse_n       (main.buse_n),
        .busak_n      (busak_n),
        .busrq_n      (busrq_n),
        .main_busak_n (lock_busak_n)
    );

    qsnd_irq_timer u_irq_timer (
        .clk48  (clk48),
        .rst    (rst),
        .cen8   (cen8),
        .m1_n   (snd.m1_n),
        .iorq_n (snd.iorq_n),
        .int_n  (int_n)
    );

    qsnd_mem_decode u_mem_decode (
        .clk48        (clk48),
        .rst          (rst),
        .cen8         (cen8),
        .snd          (snd),
        .main         (main),
        .main_busak_n (lock_busak_n),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .ram_q        (ram_q),
        .dsp_irq      (dsp_irq),
        .dsp_iack     (dsp.iack),
        .rom_addr     (rom_addr),
        .rom_cs       (rom_cs),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_we       (ram_we),
        .qsnd_wr      (qsnd_wr),
        .qsnd_reg     (qsnd_reg),
        .bus_wdata    (bus_wdata),
        .dsp_rst      (dsp_rst),
        .cpu_cen      (cpu_cen),
        .cpu_din      (cpu_din)
    );

    qsnd_work_ram u_work_ram (
        .clk48 (clk48),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .q     (ram_q)
    );

    qsnd_dsp_port u_dsp_port (
        .clk48     (clk48),
        .rst       (rst),
        .qsnd_wr   (qsnd_wr),
        .qsnd_reg  (qsnd_reg),
        .wdata     (bus_wdata),
        .dsp       (dsp),
        .dsp_irq   (dsp_irq),
        .pbus_in   (pbus_in),
        .qsnd_addr (qsnd_addr),
        .audio     (audio),
        .sample    (sample)
    );

endmodule

`default_nettype wire

// File: dv/qsnd_tb.sv
/* testbench for the sound glue top; sound CPU, main CPU, ROM and DSP are port models
   the interrupt check waits two full timer periods, about 400k cycles */
`timescale 1ns/1ps
`default_nettype none

module qsnd_tb;

    import qsnd_pkg::*;

    localparam int TMO = 100;  // cycles per ordinary wait

    logic clk48, rst, cen8, busak_n, rom_ok, qsnd_cs, sample;
    logic [2:0] cen_cnt;
    snd_bus_t snd;
    main_bus_t main;
    dsp_pio_t dsp;
    byte_t rom_data, qsnd_data, main_din, cpu_din, rd, cur_bank, b;
    logic main_busak_n, busrq_n, int_n, cpu_cen, rom_cs, dsp_rst, dsp_irq;
    rom_addr_t rom_addr;
    qrom_addr_t qsnd_addr;
    logic [15:0] pbus_in, rb_din, lo16;
    logic [23:0] cmd;
    logic [6:0] up7;
    sample_t left, right, sl, sr;
    snd_addr_t a;
    byte_t wr_c [8];
    byte_t wr_f [8];
    logic [11:0] offs [8];
    int seed, sample_cnt, base, n_cen, n_cpu, t, phase, ticks;

    qsnd_sound_top i_dut (.*);

    always #5 clk48 = ~clk48;

    always @(posedge clk48) begin
        cen_cnt <= (cen_cnt == 3'd5) ? 3'd0 : cen_cnt + 3'd1;
        cen8    <= (cen_cnt == 3'd5);  // every sixth cycle
        rom_ok  <= rom_cs;             // ROM answers one cycle late
        rom_data <= rom_pattern(rom_addr);
        if (sample) sample_cnt <= sample_cnt + 1;
    end

    // fill pattern over the whole ROM address
    function automatic byte_t rom_pattern(rom_addr_t ra);
        return ra[7:0] ^ ra[15:8] ^ {5'd0, ra[18:16]} ^ 8'h5a;
    endfunction

    function automatic rom_addr_t map_rom_addr(snd_addr_t ca, byte_t bank);
        if (!ca[15]) return rom_addr_t'(ca[14:0]);
        return rom_addr_t'(bank[3:0]) * 19'd16384 + rom_addr_t'(ca[13:0]) + 19'h0_8000;
    endfunction

    function automatic byte_t status_byte(logic irq, logic iack, byte_t bank);
        return {~(irq | iack), 3'b111, bank[3:0]};
    endfunction

    // step 0 shows the address byte and later steps the data word
    function automatic logic [15:0] pbus_word(logic [23:0] c, int step);
        return (step == 0) ? {8'd0, c[23:16]} : c[15:0];
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_rom_addr(string name, rom_addr_t got, rom_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_byte(string name, byte_t got, byte_t exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_word(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_qaddr(string name, qrom_addr_t got, qrom_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_sample(string name, sample_t got, sample_t exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic cpu_write(snd_addr_t wa, byte_t wd);
        @(posedge clk48);
        snd.addr <= wa;
        snd.dout <= wd;
        snd.mreq_n <= 1'b0;
        snd.wr_n <= 1'b0;
        repeat (2) @(posedge clk48);
        snd.mreq_n <= 1'b1;
        snd.wr_n <= 1'b1;
        repeat (2) @(posedge clk48);
    endtask

    task automatic cpu_read(snd_addr_t ra, output byte_t d);
        int w;
        @(posedge clk48);
        snd.addr <= ra;
        snd.mreq_n <= 1'b0;
        snd.rd_n <= 1'b0;
        @(posedge clk48);
        for (w = 0; w < TMO; w++) begin
            @(negedge clk48);
            if (!rom_cs || rom_ok) break;  // ROM reads wait for rom_ok
            @(posedge clk48);
        end
        if (w == TMO) report_failure("ROM read got no rom_ok in time");
        d = cpu_din;
        @(posedge clk48);
        snd.mreq_n <= 1'b1;
        snd.rd_n <= 1'b1;
        repeat (2) @(posedge clk48);
    endtask

    task automatic pulse_pids;
        @(posedge clk48) dsp.pids_n <= 1'b0;
        @(posedge clk48) dsp.pids_n <= 1'b1;
        repeat (2) @(posedge clk48);
        @(negedge clk48);
    endtask

    task automatic serial_word(sample_t w, logic p);
        @(posedge clk48);
        dsp.ser_out <= w;
        dsp.psel <= p;
        dsp.sadd <= 1'b1;
        @(posedge clk48) dsp.sadd <= 1'b0;  // falling sadd takes the word
        repeat (2) @(posedge clk48);
    endtask

    task automatic count_fetch_ticks(snd_addr_t fa);
        @(posedge clk48);
        snd.addr <= fa;
        snd.mreq_n <= 1'b0;
        snd.rd_n <= 1'b0;
        snd.m1_n <= 1'b0;
        n_cen = 0;
        n_cpu = 0;
        repeat (24) begin
            @(negedge clk48);
            n_cen += cen8;
            n_cpu += cpu_cen;
        end
        @(posedge clk48);
        snd.mreq_n <= 1'b1;
        snd.rd_n <= 1'b1;
        snd.m1_n <= 1'b1;
        repeat (3) @(posedge clk48);
    endtask

    initial begin
        seed = 32'hb9aa54c1;
        clk48 = 1'b0;
        rst = 1'b1;
        cen8 = 1'b0;
        cen_cnt = 3'd0;
        busak_n = 1'b1;
        rom_ok = 1'b0;
        rom_data = 8'h00;
        qsnd_data = 8'h00;
        snd = '{addr: 16'h0, dout: 8'h0, default: 1'b1};
        main = '{addr: 23'hc000, dout: 8'h0, ldsw_n: 1'b1, buse_n: 1'b1};
        dsp = '0;
        dsp.pods_n = 1'b1;
        dsp.pids_n = 1'b1;
        sample_cnt = 0;
        cur_bank = 8'h00;
        repeat (10) @(posedge clk48);
        rst <= 1'b0;
        @(negedge clk48);
        check_byte("reset outputs", {qsnd_cs, rom_cs, sample, dsp_irq, int_n, busrq_n,
                   main_busak_n, dsp_rst}, 8'b1000_1111);
        @(posedge clk48) qsnd_data <= byte_t'($random(seed));
        @(negedge clk48);
        check_word("rb_din", rb_din, {qsnd_data, 8'h00});

        // fixed and banked ROM reads
        repeat (4) begin
            b = byte_t'($random(seed));
            cpu_write(16'hd003, b);
            cur_bank = {4'd0, b[3:0]};
            check_byte("dsp_rst", {7'd0, dsp_rst}, {7'd0, ~b[7]});
            a = {1'b0, 15'($random(seed))};
            cpu_read(a, rd);
            check_rom_addr("rom_addr", rom_addr, map_rom_addr(a, cur_bank));
            check_byte("cpu_din", rd, rom_pattern(map_rom_addr(a, cur_bank)));
            a = {2'b10, 14'($random(seed))};
            cpu_read(a, rd);
            check_rom_addr("rom_addr", rom_addr, map_rom_addr(a, cur_bank));
            check_byte("cpu_din", rd, rom_pattern(map_rom_addr(a, cur_bank)));
        end

        // both RAM windows at the same offsets
        for (int i = 0; i < 8; i++) begin
            offs[i] = 12'($random(seed));
            wr_c[i] = byte_t'($random(seed));
            wr_f[i] = ~wr_c[i];
            cpu_write({4'hc, offs[i]}, wr_c[i]);
            cpu_write({4'hf, offs[i]}, wr_f[i]);
        end
        for (int i = 0; i < 8; i++) begin
            cpu_read({4'hc, offs[i]}, rd);
            check_byte("ram C000", rd, wr_c[i]);
            cpu_read({4'hf, offs[i]}, rd);
            check_byte("ram F000", rd, wr_f[i]);
        end
        cpu_read(16'hd007, rd);
        check_byte("status", rd, status_byte(1'b0, 1'b0, cur_bank));

        // command to the DSP
        cmd = 24'($random(seed));
        cpu_write(16'hd000, cmd[15:8]);
        cpu_write(16'hd001, cmd[7:0]);
        cpu_write(16'hd002, cmd[23:16]);
        @(negedge clk48);
        if (!dsp_irq) report_failure("dsp_irq not raised after the D002 write");
        cpu_read(16'hd007, rd);
        check_byte("status", rd, status_byte(1'b1, 1'b0, cur_bank));
        check_word("pbus_in", pbus_in, pbus_word(cmd, 0));
        pulse_pids();
        if (dsp_irq) report_failure("dsp_irq still set after the first pids_n pulse");
        check_word("pbus_in", pbus_in, pbus_word(cmd, 1));
        pulse_pids();
        check_word("pbus_in", pbus_in, pbus_word(cmd, 2));

        // sample ROM address
        lo16 = 16'($random(seed));
        up7 = 7'($random(seed));
        @(posedge clk48);
        dsp.pbus_out <= lo16;
        dsp.pods_n <= 1'b0;
        @(posedge clk48) dsp.pods_n <= 1'b1;
        @(posedge clk48);
        dsp.ab <= {1'b1, 8'd0, up7};
        dsp.cen_cko <= 1'b1;
        @(posedge clk48);
        dsp.ab <= 16'h0;
        dsp.cen_cko <= 1'b0;
        repeat (2) @(posedge clk48);
        @(negedge clk48);
        check_qaddr("qsnd_addr", qsnd_addr, {up7, lo16});

        // each audio frame loads right under psel high and left under psel low
        @(posedge clk48) dsp.psel <= 1'b1;
        repeat (4) @(posedge clk48);
        base = sample_cnt;
        for (int f = 1; f <= 4; f++) begin
            sl = sample_t'($random(seed));
            sr = sample_t'($random(seed));
            serial_word(sr, 1'b1);
            serial_word(sl, 1'b0);
            @(posedge clk48) dsp.psel <= 1'b1;
            repeat (3) @(posedge clk48);
            @(negedge clk48);
            check_sample("left", left, sl);
            check_sample("right", right, sr);
            if (sample_cnt - base != f) report_failure("wrong number of sample pulses");
        end

        // main CPU takes the bus and writes shared RAM
        b = byte_t'($random(seed));
        @(posedge clk48) main.buse_n <= 1'b0;
        @(negedge clk48);
        if (busrq_n) report_failure("busrq_n did not follow buse_n");
        @(posedge clk48) busak_n <= 1'b0;
        for (t = 0; t < TMO && main_busak_n; t++) @(negedge clk48);
        if (main_busak_n) report_failure("main_busak_n never fell after busak_n");
        @(posedge clk48);
        main.addr <= 23'hc0a5;
        main.dout <= b;
        main.ldsw_n <= 1'b0;
        repeat (2) @(posedge clk48);
        main.ldsw_n <= 1'b1;  // main CPU reads the byte back
        repeat (3) @(posedge clk48);
        @(negedge clk48);
        check_byte("main_din", main_din, b);
        @(posedge clk48) main.buse_n <= 1'b1;
        @(posedge clk48) busak_n <= 1'b1;
        for (t = 0; t < TMO && !main_busak_n; t++) @(negedge clk48);
        if (!main_busak_n) report_failure("main_busak_n stayed low after release");
        cpu_read(16'hc0a5, rd);
        check_byte("shared ram", rd, b);

        // opcode fetch wait
        count_fetch_ticks(16'h5123);
        if (n_cen - n_cpu != 1) report_failure("upper fetch did not drop one cen8 tick");
        count_fetch_ticks(16'h1234);
        if (n_cen != n_cpu) report_failure("lower fetch lost a cen8 tick");

        // interrupt period and acknowledge
        for (t = 0; t < 6 * IRQ_PERIOD + TMO && int_n; t++) @(negedge clk48);
        if (int_n) report_failure("int_n never fell");
        ticks = 0;
        phase = 0;
        for (t = 0; t < 6 * IRQ_PERIOD + TMO; t++) begin
            @(posedge clk48);
            ticks += cen8;
            if (phase == 0) begin
                snd.m1_n <= 1'b0;
                snd.iorq_n <= 1'b0;
                phase = 1;
            end else if (phase == 2) begin
                snd.m1_n <= 1'b1;
                snd.iorq_n <= 1'b1;
                phase = 3;
            end
            @(negedge clk48);
            if (phase == 1 && int_n) phase = 2;
            if (phase == 3 && !int_n) break;
        end
        if (phase != 3 || int_n) report_failure("interrupt acknowledge or next period missing");
        if (ticks != IRQ_PERIOD) report_failure("interrupt period is not IRQ_PERIOD ticks");

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
src/qsnd_pkg.sv
src/qsnd_bus_lock.sv
src/qsnd_irq_timer.sv
src/qsnd_mem_decode.sv
src/qsnd_work_ram.sv
src/qsnd_dsp_port.sv
src/qsnd_sound_top.sv
dv/qsnd_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module qsnd_tb -f build.f \
    -o qsnd_sim > build.log 2>&1 \
    && ./obj_dir/qsnd_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
